/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_mgmt_core
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
verilog/mgmt_pkg.sv
verilog/sync_2ff.sv
verilog/mgmt_io_mux.sv
verilog/hk_spi_slave.sv
verilog/hk_regs.sv
verilog/core_clocking.sv
verilog/mgmt_core.sv
verif/mgmt_core_chk.sv
verif/tb_mgmt_core.sv

/* verif/mgmt_core_chk.sv */
// Bound assertions on SPI deselect, bypass clock enable and core reset of the management top
module mgmt_core_chk
	import mgmt_pkg::*;
(
	input logic      clock,
	input logic      rst_i,
	input spi_pins_t spi_sync_i,
	input logic      sdo_enb_i,
	input logic      ext_clk_sel_i,
	input logic      core_clk_en_i,
	input logic      core_rst_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int unsigned fail_cnt = 0;

	// SDO stays released on the cycle after the slave sees CSB high
	sdo_released: assert property (@(posedge clock) disable iff (rst_i)
		spi_sync_i.csb |=> sdo_enb_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("sdo_enb low after synchronized CSB was high");
	end

	// External clock runs the core every cycle
	bypass_enable: assert property (@(posedge clock) disable iff (rst_i)
		ext_clk_sel_i |-> core_clk_en_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("core clock enable low with external clock selected");
	end

	core_reset_follows: assert property (@(posedge clock) rst_i |=> core_rst_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("core reset low on the cycle after rst_i");
	end

endmodule

bind mgmt_core mgmt_core_chk u_chk (
	.clock         (clock),
	.rst_i         (rst_i),
	.spi_sync_i    (spi_sync),
	.sdo_enb_i     (sdo_enb_o),
	.ext_clk_sel_i (ext_clk_sel_o),
	.core_clk_en_i (core_clk_en_o),
	.core_rst_i    (core_rst_o)
);

/* verif/tb_mgmt_core.sv */
// Testbench for the management front end with random SPI frames, register model and port checks
module tb_mgmt_core
	import mgmt_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_HOLD = 4;
	// SCK pin rise to register update, two sync stages plus decode and write
	localparam int SPI_WR_LAT = 4;

	logic                  clock;
	logic                  rst_i;
	spi_pins_t             spi_pad;
	logic [IO_W-1:0]       mgmt_out;
	logic                  hk_connect;
	logic                  sdo_oenb_state;
	logic                  jtag_oenb_state;
	logic [MASK_REV_W-1:0] mask_rev;
	logic                  sdo_o;
	logic                  sdo_enb_o;
	logic                  jtag_o;
	logic                  pll_ena_o;
	logic                  ext_clk_sel_o;
	logic [2:0]            pll_sel_o;
	logic [4:0]            pll_div_o;
	logic                  irq_o;
	logic                  core_clk_en_o;
	logic                  core_rst_o;

	// Register model
	logic       m_ena;
	logic       m_bypass;
	logic [2:0] m_sel;
	logic [4:0] m_div;
	logic       m_irq;
	logic       m_soft;

	// Frame goes out on mgmt_out bits 4/3/2 instead of the pads
	logic        via_mgmt;
	int unsigned cycle_cnt;
	int unsigned last_rise_cyc;
	int unsigned rst_fall_cyc;
	logic        core_rst_prev;

	mgmt_core #(
		.RST_HOLD (RST_HOLD)
	) u_dut (
		.clock             (clock),
		.rst_i             (rst_i),
		.spi_pad_i         (spi_pad),
		.mgmt_out_i        (mgmt_out),
		.hk_connect_i      (hk_connect),
		.sdo_oenb_state_i  (sdo_oenb_state),
		.jtag_oenb_state_i (jtag_oenb_state),
		.mask_rev_i        (mask_rev),
		.sdo_o             (sdo_o),
		.sdo_enb_o         (sdo_enb_o),
		.jtag_o            (jtag_o),
		.pll_ena_o         (pll_ena_o),
		.ext_clk_sel_o     (ext_clk_sel_o),
		.pll_sel_o         (pll_sel_o),
		.pll_div_o         (pll_div_o),
		.irq_o             (irq_o),
		.core_clk_en_o     (core_clk_en_o),
		.core_rst_o        (core_rst_o)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// Remember the cycle of the last core reset release
	always @(negedge clock) begin
		if (core_rst_prev && !core_rst_o) begin
			rst_fall_cyc = cycle_cnt;
		end
		core_rst_prev = core_rst_o;
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		$display("Test failed");
		$fatal(1, "Wait for %s never completed", what);
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic set_pins(input logic sck, input logic csb, input logic sdi);
		if (via_mgmt) begin
			mgmt_out[4] = sck;
			mgmt_out[3] = csb;
			mgmt_out[2] = sdi;
		end else begin
			spi_pad = '{sck: sck, csb: csb, sdi: sdi};
		end
	endtask

	// One SCK period, each level held 4 to 7 clocks, SDO taken mid high phase
	task automatic spi_bit(input logic sdi, output logic sdo);
		int lo;
		int hi;
		lo = 4 + int'($urandom % 4);
		hi = 4 + int'($urandom % 4);
		set_pins(1'b0, 1'b0, sdi);
		wait_cycles(lo);
		set_pins(1'b1, 1'b0, sdi);
		last_rise_cyc = cycle_cnt;
		wait_cycles(hi / 2);
		@(negedge clock);
		sdo = sdo_o;
		wait_cycles(hi - hi / 2);
	endtask

	// Command, address, data; fewer than 24 bits makes an aborted frame
	task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] addr,
			input logic [7:0] data, input int nbits, output logic [7:0] rdata);
		logic [23:0] word;
		logic        sdo;
		int          i;
		word  = {cmd, addr, data};
		rdata = '0;
		set_pins(1'b0, 1'b0, 1'b0);
		wait_cycles(4);
		for (i = 0; i < nbits; i++) begin
			spi_bit(word[23 - i], sdo);
			if (i >= 16) begin
				rdata = {rdata[6:0], sdo};
			end
		end
		set_pins(1'b0, 1'b0, 1'b0);
		wait_cycles(4);
		// SDO driven from the read strobe until deselect
		check("sdo_enb_o before deselect", 32'(sdo_enb_o),
			(cmd == CMD_READ && nbits >= 16) ? 32'd0 : 32'd1);
		set_pins(1'b0, 1'b1, 1'b0);
		// Slave releases SDO once deselect is through the synchronizer
		for (i = 0; i < 10; i++) begin
			@(negedge clock);
			if (sdo_enb_o) begin
				break;
			end
		end
		if (!sdo_enb_o) begin
			timeout_fail("sdo_enb_o high after CSB rise");
		end
		wait_cycles(1);
	endtask

	task automatic model_reset();
		m_ena    = 1'b0;
		m_bypass = 1'b1;
		m_sel    = '0;
		m_div    = '0;
		m_irq    = 1'b0;
		m_soft   = 1'b0;
	endtask

	task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
		case (addr)
			REG_PLL_CTL: begin
				m_ena    = data[0];
				m_bypass = data[1];
			end
			REG_PLL_SEL: m_sel  = data[2:0];
			REG_PLL_DIV: m_div  = data[4:0];
			REG_IRQ:     m_irq  = data[0];
			REG_RESET:   m_soft = data[0];
			default: ;
		endcase
	endtask

	function automatic logic [7:0] model_read(input logic [7:0] addr);
		case (addr)
			REG_MASK_REV0: return mask_rev[7:0];
			REG_MASK_REV1: return mask_rev[15:8];
			REG_MASK_REV2: return mask_rev[23:16];
			REG_MASK_REV3: return mask_rev[31:24];
			REG_PLL_CTL:   return {6'd0, m_bypass, m_ena};
			REG_PLL_SEL:   return {5'd0, m_sel};
			REG_PLL_DIV:   return {3'd0, m_div};
			REG_IRQ:       return {7'd0, m_irq};
			REG_RESET:     return {7'd0, m_soft};
			default:       return 8'h00;
		endcase
	endfunction

	task automatic compare_ports();
		@(negedge clock);
		check("pll_ena_o", 32'(pll_ena_o), 32'(m_ena));
		check("ext_clk_sel_o", 32'(ext_clk_sel_o), 32'(m_bypass));
		check("pll_sel_o", 32'(pll_sel_o), 32'(m_sel));
		check("pll_div_o", 32'(pll_div_o), 32'(m_div));
		check("irq_o", 32'(irq_o), 32'(m_irq));
		wait_cycles(1);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		spi_frame(CMD_WRITE, addr, data, 24, unused);
		model_write(addr, data);
		compare_ports();
	endtask

	task automatic read_and_compare(input logic [7:0] addr);
		logic [7:0] rdata;
		spi_frame(CMD_READ, addr, 8'h00, 24, rdata);
		check($sformatf("read of %02h", addr), 32'(rdata), 32'(model_read(addr)));
	endtask

	initial begin : main
		logic [7:0] addr;
		logic [7:0] data;
		logic [7:0] cmd;
		logic [7:0] rdata;
		logic [4:0] div;
		int         cnt;
		int         i;
		void'($urandom(32'habee_acfc));
		rst_i           = 1'b1;
		spi_pad         = SPI_IDLE;
		mgmt_out        = '0;
		hk_connect      = 1'b0;
		sdo_oenb_state  = 1'b1;
		jtag_oenb_state = 1'b1;
		mask_rev        = $urandom;
		via_mgmt        = 1'b0;
		cycle_cnt       = 0;
		last_rise_cyc   = 0;
		rst_fall_cyc    = 0;
		core_rst_prev   = 1'b0;
		model_reset();
		wait_cycles(2);
		rst_i = 1'b0;

		// Reset state, then core reset release within RST_HOLD+2 cycles
		@(negedge clock);
		check("pll_ena_o after reset", 32'(pll_ena_o), 32'd0);
		check("ext_clk_sel_o after reset", 32'(ext_clk_sel_o), 32'd1);
		check("irq_o after reset", 32'(irq_o), 32'd0);
		check("sdo_enb_o after reset", 32'(sdo_enb_o), 32'd1);
		check("core_rst_o after reset", 32'(core_rst_o), 32'd1);
		for (i = 0; i < RST_HOLD + 2 && core_rst_o; i++) begin
			@(negedge clock);
		end
		if (core_rst_o) begin
			timeout_fail("core_rst_o release after reset");
		end
		wait_cycles(1);

		// Pad overrides are combinational, pads idle meanwhile
		for (i = 0; i < 50; i++) begin
			mgmt_out        = 16'($urandom);
			sdo_oenb_state  = 1'($urandom % 2);
			jtag_oenb_state = 1'($urandom % 2);
			@(negedge clock);
			if (!sdo_oenb_state) begin
				check("sdo_o override", 32'(sdo_o), 32'(mgmt_out[1]));
			end
			check("jtag_o", 32'(jtag_o), jtag_oenb_state ? 32'd0 : 32'(mgmt_out[0]));
			wait_cycles(1);
		end
		sdo_oenb_state  = 1'b1;
		jtag_oenb_state = 1'b1;

		for (i = 0; i < 200; i++) begin
			addr = 8'($urandom % 16);
			data = 8'($urandom);
			if ($urandom % 2) begin
				write_reg(addr, data);
			end else begin
				read_and_compare(addr);
			end
		end

		// Aborted writes and unknown commands leave the registers alone
		for (i = 0; i < 20; i++) begin
			addr = 8'(8 + $urandom % 5);
			spi_frame(CMD_WRITE, addr, 8'($urandom), 1 + int'($urandom % 23), rdata);
			compare_ports();
			read_and_compare(addr);
		end
		for (i = 0; i < 10; i++) begin
			cmd  = 8'($urandom);
			addr = 8'(8 + $urandom % 5);
			if (cmd == CMD_WRITE || cmd == CMD_READ) begin
				cmd = cmd ^ 8'h01;
			end
			spi_frame(cmd, addr, 8'($urandom), 24, rdata);
			compare_ports();
			read_and_compare(addr);
		end

		// Divided enable, about one pulse per div cycles
		div = 5'(2 + $urandom % 30);
		write_reg(REG_PLL_CTL, {6'd0, 1'b0, 1'($urandom % 2)});
		write_reg(REG_PLL_DIV, {3'd0, div});
		cnt = 0;
		for (i = 0; i < 10 * int'(div); i++) begin
			@(negedge clock);
			if (core_clk_en_o) begin
				cnt++;
			end
		end
		if (cnt < 9 || cnt > 11) begin
			check($sformatf("enable pulses for div %0d", div), 32'(cnt), 32'd10);
		end
		wait_cycles(1);
		write_reg(REG_PLL_CTL, {6'd0, 1'b1, m_ena});
		for (i = 0; i < 20; i++) begin
			@(negedge clock);
			check("core_clk_en_o in bypass", 32'(core_clk_en_o), 32'd1);
		end
		wait_cycles(1);

		// Soft reset holds the core, release measured from the last SCK rise
		write_reg(REG_RESET, 8'h01);
		for (i = 0; i < 20; i++) begin
			@(negedge clock);
			check("core_rst_o under soft reset", 32'(core_rst_o), 32'd1);
		end
		wait_cycles(1);
		write_reg(REG_RESET, 8'h00);
		if (rst_fall_cyc <= last_rise_cyc ||
				rst_fall_cyc - last_rise_cyc > SPI_WR_LAT + RST_HOLD + 2) begin
			check("core reset release latency", rst_fall_cyc - last_rise_cyc,
				SPI_WR_LAT + RST_HOLD + 2);
		end
		read_and_compare(REG_RESET);

		// Management side drives the slave
		mgmt_out   = 16'($urandom);
		mgmt_out[4:2] = 3'b010;
		hk_connect = 1'b1;
		via_mgmt   = 1'b1;
		wait_cycles(4);
		write_reg(REG_PLL_SEL, 8'($urandom));
		read_and_compare(REG_PLL_SEL);
		via_mgmt   = 1'b0;
		hk_connect = 1'b0;
		wait_cycles(4);

		if (u_dut.u_chk.fail_cnt == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "Bound assertions failed %0d times", u_dut.u_chk.fail_cnt);
		end
	end

endmodule

/* verilog/core_clocking.sv */
// Core clock enable divider and stretched core reset
module core_clocking
	import mgmt_pkg::*;
#(
	parameter int RST_HOLD = 4
) (
	input  logic     clock,
	input  logic     rst_i,
	input  pll_cfg_t pll_cfg_i,
	// Soft reset level from the register file
	input  logic     soft_rst_i,
	output logic     core_clk_en_o,
	output logic     core_rst_o
);

	// Wide enough to hold RST_HOLD, even when it is zero
	localparam int HOLD_W = $clog2(RST_HOLD + 2);

	logic [4:0]        div_q;
	logic [4:0]        div_cnt_q;
	logic [HOLD_W-1:0] hold_cnt_q;
	logic              core_rst_q;

	// Free running divider, restarted on any divider change
	always_ff @(posedge clock) begin
		if (rst_i) begin
			div_q     <= '0;
			div_cnt_q <= '0;
		end else if (pll_cfg_i.div != div_q) begin
			div_q     <= pll_cfg_i.div;
			div_cnt_q <= '0;
		end else if (div_cnt_q >= div_q - 5'd1) begin
			div_cnt_q <= '0;
		end else begin
			div_cnt_q <= div_cnt_q + 5'd1;
		end
	end

	// External clock or trivial divide runs every cycle
	assign core_clk_en_o = pll_cfg_i.bypass | (pll_cfg_i.div < 5'd2) | (div_cnt_q == 5'd0);

	// Reset held while a source is active, then RST_HOLD more cycles
	always_ff @(posedge clock) begin
		if (rst_i || soft_rst_i) begin
			hold_cnt_q <= HOLD_W'(RST_HOLD);
			core_rst_q <= 1'b1;
		end else if (hold_cnt_q != '0) begin
			hold_cnt_q <= hold_cnt_q - 1'b1;
			core_rst_q <= 1'b1;
		end else begin
			core_rst_q <= 1'b0;
		end
	end

	assign core_rst_o = core_rst_q;

endmodule

/* verilog/hk_regs.sv */
// Housekeeping register file with clock controls, soft reset, interrupt and mask revision
module hk_regs
	import mgmt_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst_i,
	input  logic [7:0]            addr_i,
	input  logic [7:0]            wdata_i,
	input  logic                  we_i,
	// Metal programmed revision word
	input  logic [MASK_REV_W-1:0] mask_rev_i,
	output logic [7:0]            rdata_o,
	output pll_cfg_t              pll_cfg_o,
	output logic                  soft_rst_o,
	output logic                  irq_o
);

	pll_cfg_t pll_cfg_q;
	logic     soft_rst_q;
	logic     irq_q;

	// Writable fields, unmapped addresses drop the write
	always_ff @(posedge clock) begin
		if (rst_i) begin
			pll_cfg_q  <= PLL_CFG_RST;
			soft_rst_q <= 1'b0;
			irq_q      <= 1'b0;
		end else if (we_i) begin
			case (addr_i)
				REG_PLL_CTL: begin
					pll_cfg_q.ena    <= wdata_i[0];
					pll_cfg_q.bypass <= wdata_i[1];
				end
				REG_PLL_SEL: pll_cfg_q.sel  <= wdata_i[2:0];
				REG_PLL_DIV: pll_cfg_q.div  <= wdata_i[4:0];
				REG_IRQ:     irq_q          <= wdata_i[0];
				REG_RESET:   soft_rst_q     <= wdata_i[0];
				default: ;
			endcase
		end
	end

	// Read mux, unused bits and holes read back as zero
	always_comb begin
		rdata_o = '0;
		case (addr_i)
			REG_MASK_REV0: rdata_o = mask_rev_i[7:0];
			REG_MASK_REV1: rdata_o = mask_rev_i[15:8];
			REG_MASK_REV2: rdata_o = mask_rev_i[23:16];
			REG_MASK_REV3: rdata_o = mask_rev_i[31:24];
			REG_PLL_CTL:   rdata_o = {6'd0, pll_cfg_q.bypass, pll_cfg_q.ena};
			REG_PLL_SEL:   rdata_o = {5'd0, pll_cfg_q.sel};
			REG_PLL_DIV:   rdata_o = {3'd0, pll_cfg_q.div};
			REG_IRQ:       rdata_o = {7'd0, irq_q};
			REG_RESET:     rdata_o = {7'd0, soft_rst_q};
			default:       rdata_o = '0;
		endcase
	end

	assign pll_cfg_o  = pll_cfg_q;
	assign soft_rst_o = soft_rst_q;
	assign irq_o      = irq_q;

endmodule

/* verilog/hk_spi_slave.sv */
// Housekeeping SPI slave with oversampled SCK, frame decode and register strobes
module hk_spi_slave
	import mgmt_pkg::*;
(
	input  logic       clock,
	input  logic       rst_i,
	// Synchronized SPI pins
	input  spi_pins_t  spi_i,
	// Register read data, valid while addr_o is stable
	input  logic [7:0] rdata_i,
	output logic [7:0] addr_o,
	output logic [7:0] wdata_o,
	output logic       we_o,
	output logic       re_o,
	output logic       sdo_o,
	output logic       sdo_enb_o
);

	// Frame phase, one byte each except ignore
	typedef enum logic [1:0] {
		PH_CMD,
		PH_ADDR,
		PH_DATA,
		PH_IGNORE
	} phase_e;

	phase_e     phase_q;
	logic [2:0] bit_cnt_q;
	logic       sck_q;
	logic [7:0] shift_in_q;
	logic [7:0] shift_out_q;
	logic [7:0] addr_q;
	logic       is_write_q;
	logic       we_q;
	logic       re_q;
	logic       sdo_enb_q;

	logic       sck_rise;
	logic       sck_fall;
	logic       bit_take;
	logic       byte_done;
	logic [7:0] byte_in;

	// Edges of the oversampled clock
	assign sck_rise = spi_i.sck & ~sck_q;
	assign sck_fall = ~spi_i.sck & sck_q;

	// Data is taken on rising edges, nothing after the frame ends
	assign bit_take  = ~spi_i.csb & sck_rise & (phase_q != PH_IGNORE);
	assign byte_done = bit_take & (bit_cnt_q == 3'd7);
	assign byte_in   = {shift_in_q[6:0], spi_i.sdi};

	always_ff @(posedge clock) begin
		if (rst_i) begin
			phase_q     <= PH_CMD;
			bit_cnt_q   <= '0;
			sck_q       <= 1'b0;
			we_q        <= 1'b0;
			re_q        <= 1'b0;
			sdo_enb_q   <= 1'b1;
			shift_out_q <= '0;
		end else begin
			sck_q <= spi_i.sck;
			// Strobes last one cycle
			we_q  <= 1'b0;
			re_q  <= 1'b0;
			if (spi_i.csb) begin
				// Deselect drops any partial frame
				phase_q   <= PH_CMD;
				bit_cnt_q <= '0;
				sdo_enb_q <= 1'b1;
			end else begin
				if (re_q) begin
					// MSB goes out straight away
					shift_out_q <= rdata_i;
					sdo_enb_q   <= 1'b0;
				end else if (sck_fall && phase_q == PH_DATA && !is_write_q &&
						bit_cnt_q != 3'd0) begin
					shift_out_q <= {shift_out_q[6:0], 1'b0};
				end
				if (bit_take) begin
					bit_cnt_q <= bit_cnt_q + 3'd1;
				end
				if (byte_done) begin
					case (phase_q)
						PH_CMD: begin
							// Unknown commands sit out the frame
							if (byte_in == CMD_WRITE || byte_in == CMD_READ) begin
								phase_q <= PH_ADDR;
							end else begin
								phase_q <= PH_IGNORE;
							end
						end
						PH_ADDR: begin
							phase_q <= PH_DATA;
							re_q    <= ~is_write_q;
						end
						PH_DATA: begin
							phase_q <= PH_IGNORE;
							we_q    <= is_write_q;
						end
						default: phase_q <= PH_IGNORE;
					endcase
				end
			end
		end
	end

	// Shift data and decoded frame fields
	always_ff @(posedge clock) begin
		if (bit_take) begin
			shift_in_q <= byte_in;
		end
		if (byte_done && phase_q == PH_CMD) begin
			is_write_q <= (byte_in == CMD_WRITE);
		end
		if (byte_done && phase_q == PH_ADDR) begin
			addr_q <= byte_in;
		end
	end

	// Shift register holds the data byte once the write completes
	assign addr_o  = addr_q;
	assign wdata_o = shift_in_q;
	assign we_o    = we_q;
	assign re_o    = re_q;
	assign sdo_o   = shift_out_q[7];

	// Released at once when chip select goes high
	assign sdo_enb_o = sdo_enb_q | spi_i.csb;

endmodule

/* verilog/mgmt_core.sv */
// Management front end top level with pin mux, housekeeping SPI, registers and clocking
module mgmt_core
	import mgmt_pkg::*;
#(
	parameter int RST_HOLD = 4
) (
	input  logic                  clock,
	input  logic                  rst_i,
	input  spi_pins_t             spi_pad_i,
	input  logic [IO_W-1:0]       mgmt_out_i,
	input  logic                  hk_connect_i,
	input  logic                  sdo_oenb_state_i,
	input  logic                  jtag_oenb_state_i,
	input  logic [MASK_REV_W-1:0] mask_rev_i,
	output logic                  sdo_o,
	output logic                  sdo_enb_o,
	output logic                  jtag_o,
	output logic                  pll_ena_o,
	output logic                  ext_clk_sel_o,
	output logic [2:0]            pll_sel_o,
	output logic [4:0]            pll_div_o,
	output logic                  irq_o,
	output logic                  core_clk_en_o,
	output logic                  core_rst_o
);

	spi_pins_t  spi_sync;
	logic       hk_sdo;
	logic [7:0] reg_addr;
	logic [7:0] reg_wdata;
	logic [7:0] reg_rdata;
	logic       reg_we;
	pll_cfg_t   pll_cfg;
	logic       soft_rst;

	mgmt_io_mux u_io_mux (
		.clock             (clock),
		.rst_i             (rst_i),
		.spi_pad_i         (spi_pad_i),
		.mgmt_out_i        (mgmt_out_i),
		.hk_connect_i      (hk_connect_i),
		.sdo_oenb_state_i  (sdo_oenb_state_i),
		.jtag_oenb_state_i (jtag_oenb_state_i),
		.hk_sdo_i          (hk_sdo),
		.spi_sync_o        (spi_sync),
		.sdo_o             (sdo_o),
		.jtag_o            (jtag_o)
	);

	hk_spi_slave u_hk_spi (
		.clock     (clock),
		.rst_i     (rst_i),
		.spi_i     (spi_sync),
		.rdata_i   (reg_rdata),
		.addr_o    (reg_addr),
		.wdata_o   (reg_wdata),
		.we_o      (reg_we),
		.re_o      (),
		.sdo_o     (hk_sdo),
		.sdo_enb_o (sdo_enb_o)
	);

	hk_regs u_hk_regs (
		.clock      (clock),
		.rst_i      (rst_i),
		.addr_i     (reg_addr),
		.wdata_i    (reg_wdata),
		.we_i       (reg_we),
		.mask_rev_i (mask_rev_i),
		.rdata_o    (reg_rdata),
		.pll_cfg_o  (pll_cfg),
		.soft_rst_o (soft_rst),
		.irq_o      (irq_o)
	);

	core_clocking #(
		.RST_HOLD (RST_HOLD)
	) u_clocking (
		.clock         (clock),
		.rst_i         (rst_i),
		.pll_cfg_i     (pll_cfg),
		.soft_rst_i    (soft_rst),
		.core_clk_en_o (core_clk_en_o),
		.core_rst_o    (core_rst_o)
	);

	// Clock controls out to the pads
	assign pll_ena_o     = pll_cfg.ena;
	assign ext_clk_sel_o = pll_cfg.bypass;
	assign pll_sel_o     = pll_cfg.sel;
	assign pll_div_o     = pll_cfg.div;

endmodule

/* verilog/mgmt_io_mux.sv */
// SPI pin source select and synchronizer, SDO and JTAG pad output overrides
module mgmt_io_mux
	import mgmt_pkg::*;
(
	input  logic            clock,
	input  logic            rst_i,
	// Dedicated housekeeping SPI pads
	input  spi_pins_t       spi_pad_i,
	// Management SoC output data
	input  logic [IO_W-1:0] mgmt_out_i,
	// Route the management SPI master straight to the slave
	input  logic            hk_connect_i,
	// Output enable state of the shared pads, low means override
	input  logic            sdo_oenb_state_i,
	input  logic            jtag_oenb_state_i,
	// Serial data from the housekeeping slave
	input  logic            hk_sdo_i,
	output spi_pins_t       spi_sync_o,
	output logic            sdo_o,
	output logic            jtag_o
);

	// Pins before synchronization
	spi_pins_t spi_sel;

	// Management side pinout
	// SCK on bit 4, CSB on bit 3, SDI on bit 2
	always_comb begin
		if (hk_connect_i) begin
			spi_sel.sck = mgmt_out_i[4];
			spi_sel.csb = mgmt_out_i[3];
			spi_sel.sdi = mgmt_out_i[2];
		end else begin
			spi_sel = spi_pad_i;
		end
	end

	// Chip select resets high so the slave starts idle
	sync_2ff #(
		.T       (spi_pins_t),
		.RST_VAL (SPI_IDLE)
	) u_spi_sync (
		.clock (clock),
		.rst_i (rst_i),
		.d_i   (spi_sel),
		.q_o   (spi_sync_o)
	);

	// SDO pad takes management bit 1 when overridden
	assign sdo_o = sdo_oenb_state_i ? hk_sdo_i : mgmt_out_i[1];

	// No JTAG function here, pad idles low
	assign jtag_o = jtag_oenb_state_i ? 1'b0 : mgmt_out_i[0];

endmodule

/* verilog/mgmt_pkg.sv */
// Management front end package with widths, register map, SPI command codes and packed structs
package mgmt_pkg;

	// Management data vectors and mask revision word
	localparam int IO_W       = 16;
	localparam int MASK_REV_W = 32;

	// Housekeeping SPI command byte
	localparam logic [7:0] CMD_WRITE = 8'h80;
	localparam logic [7:0] CMD_READ  = 8'h40;

	// Register map, mask revision least significant byte first
	localparam logic [7:0] REG_MASK_REV0 = 8'h01;
	localparam logic [7:0] REG_MASK_REV1 = 8'h02;
	localparam logic [7:0] REG_MASK_REV2 = 8'h03;
	localparam logic [7:0] REG_MASK_REV3 = 8'h04;
	localparam logic [7:0] REG_PLL_CTL   = 8'h08;
	localparam logic [7:0] REG_PLL_SEL   = 8'h09;
	localparam logic [7:0] REG_PLL_DIV   = 8'h0A;
	localparam logic [7:0] REG_IRQ       = 8'h0B;
	localparam logic [7:0] REG_RESET     = 8'h0C;

	// Housekeeping SPI pins as seen by the slave
	typedef struct packed {
		logic sck;
		logic csb;
		logic sdi;
	} spi_pins_t;

	// Clock control fields
	typedef struct packed {
		logic       ena;
		logic       bypass;
		logic [2:0] sel;
		logic [4:0] div;
	} pll_cfg_t;

	// Idle bus has chip select deasserted
	localparam spi_pins_t SPI_IDLE = '{sck: 1'b0, csb: 1'b1, sdi: 1'b0};

	// Core runs from the external clock out of reset
	localparam pll_cfg_t PLL_CFG_RST = '{
		ena:    1'b0,
		bypass: 1'b1,
		sel:    3'd0,
		div:    5'd0
	};

endpackage

/* verilog/sync_2ff.sv */
// Two-stage synchronizer with a type parameter payload and a configurable reset value
module sync_2ff #(
	parameter type T       = logic,
	parameter T    RST_VAL = T'(0)
) (
	input  logic clock,
	input  logic rst_i,
	input  T     d_i,
	output T     q_o
);

	// First stage may go metastable
	T meta_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			meta_q <= RST_VAL;
			q_o    <= RST_VAL;
		end else begin
			meta_q <= d_i;
			q_o    <= meta_q;
		end
	end

endmodule
